/* verilog/hybridPkg.sv */
`default_nettype none

package hybridPkg;

    // Input code and frame geometry
    localparam int M = 2;
    localparam int DSR = 4;
    localparam int FRAME_W = M * DSR;
    localparam int AHEAD_FRAMES = 3;
    localparam int TAPS = DSR * AHEAD_FRAMES;

    // Arithmetic widths and scaling
    localparam int COEF_W = 8;
    localparam int ACC_W = 20;
    localparam int LEAK_SHIFT = 3;
    localparam int OUT_SHIFT = 2;
    localparam int OUT_W = 12;
    localparam int LEVEL_W = M + 2;

    // Output saturation bounds, two's complement before offset conversion
    localparam int OUT_MAX = 2 ** (OUT_W - 1) - 1;
    localparam int OUT_MIN = -(2 ** (OUT_W - 1));

    // Queue and credit sizing
    localparam int QUEUE_DEPTH = 8;
    localparam int CREDIT_W = 4;
    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    // Counter widths
    localparam int CODE_CNT_W = $clog2(DSR);
    localparam int FILL_W = $clog2(AHEAD_FRAMES);

    // Triangular lookahead taps, tap 0 weights the newest code
    localparam logic signed [COEF_W-1:0] coefTable [TAPS] = '{
        8, 16, 24, 32, 40, 48,
        48, 40, 32, 24, 16, 8
    };

    typedef enum logic {
        FILLING,
        WARM
    } fillState_t;

    // Code c stands for level 2c-3, so -3, -1, +1, +3
    function automatic logic signed [LEVEL_W-1:0] codeLevel(input logic [M-1:0] code);
        logic signed [LEVEL_W-1:0] wide;
        wide = signed'(LEVEL_W'(code));
        return (wide <<< 1) - signed'(LEVEL_W'(3));
    endfunction

endpackage

`default_nettype wire

/* verilog/linkIfs.sv */
`timescale 1ns/1ps
`default_nettype none

// Frames from the deserializer, credits flow back upstream
interface frameLink import hybridPkg::*; ();
    logic               frameValid;
    logic [FRAME_W-1:0] frameData;
    logic               frameWarm;
    logic               credit;

    modport src (output frameValid, output frameData, output frameWarm, input credit);
    modport dst (input frameValid, input frameData, input frameWarm, output credit);
endinterface

// Filter results into the output queue
interface resultLink import hybridPkg::*; ();
    logic             resValid;
    logic [OUT_W-1:0] resData;
    logic             credit;
    logic             queueEmpty;

    modport src (
        output resValid,
        output resData,
        input  credit,
        input  queueEmpty
    );
    modport dst (
        input  resValid,
        input  resData,
        output credit,
        output queueEmpty
    );
endinterface

`default_nettype wire

/* verilog/sampleDeserializer.sv */
`timescale 1ns/1ps
`default_nettype none

module sampleDeserializer import hybridPkg::*; (
    input  logic         clkDS,
    input  logic         arstN,
    input  logic [M-1:0] inCode,
    input  logic         inValid,
    frameLink.src        frame,
    output logic         overflow
);

    logic [CODE_CNT_W-1:0] codeCnt;
    logic [FILL_W-1:0]     fillCnt;
    logic [CREDIT_W-1:0]   creditCnt;
    logic [FRAME_W-1:0]    frameReg;
    fillState_t            state;
    logic                  frameDone;
    logic                  takeCredit;
    logic                  dropFrame;

    assign frameDone  = inValid && (codeCnt == CODE_CNT_W'(DSR - 1));
    assign takeCredit = frameDone && (state == WARM) && (creditCnt != '0);
    assign dropFrame  = frameDone && (state == WARM) && (creditCnt == '0);

    // Oldest code lands in the low bits
    always_ff @(posedge clkDS) begin
        if (inValid) begin
            frameReg[M*codeCnt +: M] <= inCode;
        end
    end

    // Frame register is stable for the whole frameValid cycle
    assign frame.frameData = frameReg;

    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            codeCnt          <= '0;
            fillCnt          <= '0;
            state            <= FILLING;
            creditCnt        <= CREDIT_W'(QUEUE_DEPTH);
            overflow         <= 1'b0;
            frame.frameValid <= 1'b0;
            frame.frameWarm  <= 1'b0;
        end else begin
            if (frameDone) begin
                codeCnt <= '0;
            end else if (inValid) begin
                codeCnt <= codeCnt + 1'b1;
            end

            // Cold frames always go through to prime the window
            frame.frameValid <= frameDone && !dropFrame;
            frame.frameWarm  <= frameDone && (state == WARM);

            if (frameDone && state == FILLING) begin
                fillCnt <= fillCnt + 1'b1;
                if (fillCnt == FILL_W'(AHEAD_FRAMES - 1)) begin
                    state <= WARM;
                end
            end

            creditCnt <= creditCnt - CREDIT_W'(takeCredit) + CREDIT_W'(frame.credit);

            // Sticky until reset
            if (dropFrame) begin
                overflow <= 1'b1;
            end
        end
    end

    // Queue never returns more credits than it has entries
    assert property (@(posedge clkDS) disable iff (!arstN)
        creditCnt <= CREDIT_W'(QUEUE_DEPTH));

endmodule

`default_nettype wire

/* verilog/lookaheadFir.sv */
`timescale 1ns/1ps
`default_nettype none

module lookaheadFir import hybridPkg::*; (
    input  logic                    clkDS,
    input  logic                    arstN,
    input  logic                    shiftIn,
    input  logic [FRAME_W-1:0]      frameData,
    output logic signed [ACC_W-1:0] sum,
    output logic signed [ACC_W-1:0] leaving
);

    logic [FRAME_W-1:0]      window [AHEAD_FRAMES];
    logic [AHEAD_FRAMES-1:0] slotFull;
    logic signed [ACC_W-1:0] partial [AHEAD_FRAMES];
    logic signed [ACC_W-1:0] windowTotal;

    // Weighted sum of one frame sitting in window slot `slot`
    function automatic logic signed [ACC_W-1:0] weighFrame(
        input logic [FRAME_W-1:0] fr,
        input int                 slot
    );
        logic signed [ACC_W-1:0] acc;
        acc = '0;
        for (int k = 0; k < DSR; k++) begin
            // Newest code of the frame meets the lowest tap of its slot
            acc += ACC_W'(codeLevel(fr[M*k +: M])) *
                   ACC_W'(coefTable[slot*DSR + DSR - 1 - k]);
        end
        return acc;
    endfunction

    function automatic logic signed [ACC_W-1:0] frameLevelSum(input logic [FRAME_W-1:0] fr);
        logic signed [ACC_W-1:0] acc;
        acc = '0;
        for (int k = 0; k < DSR; k++) begin
            acc += ACC_W'(codeLevel(fr[M*k +: M]));
        end
        return acc;
    endfunction

    // Stage 1 works on the window as it will look after the shift
    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            window   <= '{default: '0};
            partial  <= '{default: '0};
            slotFull <= '0;
            leaving  <= '0;
        end else if (shiftIn) begin
            window[0]  <= frameData;
            partial[0] <= weighFrame(frameData, 0);
            for (int i = 1; i < AHEAD_FRAMES; i++) begin
                window[i]  <= window[i-1];
                partial[i] <= weighFrame(window[i-1], i);
            end
            slotFull <= {slotFull[AHEAD_FRAMES-2:0], 1'b1};
            // Empty slots hold no real frame yet
            leaving  <= slotFull[AHEAD_FRAMES-1] ?
                        frameLevelSum(window[AHEAD_FRAMES-1]) : '0;
        end
    end

    always_comb begin
        windowTotal = '0;
        for (int i = 0; i < AHEAD_FRAMES; i++) begin
            windowTotal += partial[i];
        end
    end

    // Stage 2
    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            sum <= '0;
        end else begin
            sum <= windowTotal;
        end
    end

    // Four codes per frame, at most one code per cycle
    assert property (@(posedge clkDS) disable iff (!arstN) shiftIn |=> !shiftIn);

endmodule

`default_nettype wire

/* verilog/lookbackRecursion.sv */
`timescale 1ns/1ps
`default_nettype none

// Leaky integrator over frames that have left the lookahead window.
// Carries the long history the short FIR cannot see.
module lookbackRecursion import hybridPkg::*; (
    input  logic                    clkDS,
    input  logic                    arstN,
    input  logic                    step,
    input  logic signed [ACC_W-1:0] leaving,
    output logic signed [ACC_W-1:0] state
);

    logic signed [ACC_W-1:0] leak;
    logic signed [ACC_W-1:0] nextState;

    // Leak of 1/2^LEAK_SHIFT per step
    assign leak      = state >>> LEAK_SHIFT;
    assign nextState = state - leak + leaving;

    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            state <= '0;
        end else if (step) begin
            state <= nextState;
        end
    end

endmodule

`default_nettype wire

/* verilog/filterCore.sv */
`timescale 1ns/1ps
`default_nettype none

module filterCore import hybridPkg::*; (
    input  logic   clkDS,
    input  logic   arstN,
    frameLink.dst  frame,
    resultLink.src result
);

    logic signed [ACC_W-1:0] firSum;
    logic signed [ACC_W-1:0] firLeaving;
    logic signed [ACC_W-1:0] recState;
    logic signed [ACC_W:0]   total;
    logic signed [ACC_W:0]   scaled;
    logic signed [OUT_W-1:0] clipped;
    logic                    stepPending;
    logic [1:0]              warmPipe;

    lookaheadFir lookaheadFir_i (
        .clkDS     (clkDS),
        .arstN     (arstN),
        .shiftIn   (frame.frameValid),
        .frameData (frame.frameData),
        .sum       (firSum),
        .leaving   (firLeaving)
    );

    // Stepped a cycle after the shift, once leaving is registered
    lookbackRecursion lookbackRecursion_i (
        .clkDS   (clkDS),
        .arstN   (arstN),
        .step    (stepPending),
        .leaving (firLeaving),
        .state   (recState)
    );

    // One extra bit so the sum cannot wrap
    always_comb begin
        total  = $signed({firSum[ACC_W-1], firSum}) + $signed({recState[ACC_W-1], recState});
        scaled = total >>> OUT_SHIFT;
        if (scaled > OUT_MAX) begin
            clipped = OUT_W'(OUT_MAX);
        end else if (scaled < OUT_MIN) begin
            clipped = OUT_W'(OUT_MIN);
        end else begin
            clipped = scaled[OUT_W-1:0];
        end
    end

    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            stepPending     <= 1'b0;
            warmPipe        <= '0;
            result.resValid <= 1'b0;
            frame.credit    <= 1'b0;
        end else begin
            stepPending     <= frame.frameValid;
            // FIR sum and recursion state both settle two cycles after the shift
            warmPipe        <= {warmPipe[0], frame.frameValid && frame.frameWarm};
            result.resValid <= warmPipe[1];
            frame.credit    <= result.credit;
        end
    end

    // Offset binary out
    always_ff @(posedge clkDS) begin
        if (warmPipe[1]) begin
            result.resData <= {~clipped[OUT_W-1], clipped[OUT_W-2:0]};
        end
    end

endmodule

`default_nettype wire

/* verilog/outputQueue.sv */
`timescale 1ns/1ps
`default_nettype none

module outputQueue import hybridPkg::*; (
    input  logic             clkDS,
    input  logic             arstN,
    resultLink.dst           result,
    output logic [OUT_W-1:0] outData,
    output logic             outValid,
    input  logic             outReady
);

    logic [OUT_W-1:0]    mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]    wrPtr;
    logic [PTR_W-1:0]    rdPtr;
    logic [CREDIT_W-1:0] count;
    logic                push;
    logic                pop;
    logic                full;

    assign push = result.resValid;
    assign pop  = outValid && outReady;
    assign full = (count == CREDIT_W'(QUEUE_DEPTH));

    assign result.queueEmpty = (count == '0);
    assign outValid          = !result.queueEmpty;

    // Head entry stays put until it is popped
    assign outData = mem[rdPtr];

    always_ff @(posedge clkDS) begin
        if (push) begin
            mem[wrPtr] <= result.resData;
        end
    end

    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            wrPtr         <= '0;
            rdPtr         <= '0;
            count         <= '0;
            result.credit <= 1'b0;
        end else begin
            // Pointers wrap on their own, depth is a power of two
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count         <= count + CREDIT_W'(push) - CREDIT_W'(pop);
            result.credit <= pop;
        end
    end

    // Upstream credit accounting keeps the queue from overrunning
    assert property (@(posedge clkDS) disable iff (!arstN) push |-> !full);

endmodule

`default_nettype wire

/* verilog/hybridDecimator.sv */
`timescale 1ns/1ps
`default_nettype none

module hybridDecimator import hybridPkg::*; (
    input  logic             clkDS,
    input  logic             arstN,
    input  logic [M-1:0]     inCode,
    input  logic             inValid,
    output logic [OUT_W-1:0] outData,
    output logic             outValid,
    input  logic             outReady,
    output logic             overflow
);

    frameLink  frameBus ();
    resultLink resultBus ();

    sampleDeserializer sampleDeserializer_i (
        .clkDS    (clkDS),
        .arstN    (arstN),
        .inCode   (inCode),
        .inValid  (inValid),
        .frame    (frameBus.src),
        .overflow (overflow)
    );

    filterCore filterCore_i (
        .clkDS  (clkDS),
        .arstN  (arstN),
        .frame  (frameBus.dst),
        .result (resultBus.src)
    );

    outputQueue outputQueue_i (
        .clkDS    (clkDS),
        .arstN    (arstN),
        .result   (resultBus.dst),
        .outData  (outData),
        .outValid (outValid),
        .outReady (outReady)
    );

endmodule

`default_nettype wire

/* tb/tbModel.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Reference model of the decimator, included into the testbench module

// Levels of the last TAPS codes, index 0 is the newest
int modelHist [TAPS];
// Level sum of each frame in the window, index 0 is the newest
int modelWindowSums [AHEAD_FRAMES];
int modelRec;
int modelShifts;
int modelWarmSent;
// Set while the queue returns no credits at all
bit holdCredits;
int expQ [$];

function automatic int levelOf(input logic [M-1:0] code);
    return 2 * int'(code) - 3;
endfunction

// Triangle 1..6,6..1 scaled by 8
function automatic int tapWeight(input int tap);
    if (tap < TAPS / 2) begin
        return 8 * (tap + 1);
    end
    return 8 * (TAPS - tap);
endfunction

function automatic int toOffsetBinary(input int total);
    int top;
    int scaled;
    top = (1 << (OUT_W - 1)) - 1;
    scaled = total >>> OUT_SHIFT;
    if (scaled > top) begin
        scaled = top;
    end else if (scaled < -top - 1) begin
        scaled = -top - 1;
    end
    // Inverting the MSB adds half the range
    return scaled + top + 1;
endfunction

task automatic modelReset();
    for (int t = 0; t < TAPS; t++) begin
        modelHist[t] = 0;
    end
    for (int i = 0; i < AHEAD_FRAMES; i++) begin
        modelWindowSums[i] = 0;
    end
    modelRec = 0;
    modelShifts = 0;
    modelWarmSent = 0;
    expQ.delete();
endtask

// One completed frame, codes oldest first in the low bits
task automatic modelFrame(input logic [FRAME_W-1:0] frame);
    int leaving;
    int levelSum;
    int fir;
    bit warm;
    warm = (modelShifts >= AHEAD_FRAMES);
    // Warm frame with no credit left is lost before the filter
    if (!(warm && holdCredits && modelWarmSent >= QUEUE_DEPTH)) begin
        leaving = warm ? modelWindowSums[AHEAD_FRAMES-1] : 0;
        levelSum = 0;
        for (int k = 0; k < DSR; k++) begin
            for (int t = TAPS - 1; t > 0; t--) begin
                modelHist[t] = modelHist[t-1];
            end
            modelHist[0] = levelOf(frame[M*k +: M]);
            levelSum += modelHist[0];
        end
        for (int i = AHEAD_FRAMES - 1; i > 0; i--) begin
            modelWindowSums[i] = modelWindowSums[i-1];
        end
        modelWindowSums[0] = levelSum;
        modelRec = modelRec - (modelRec >>> LEAK_SHIFT) + leaving;
        fir = 0;
        for (int t = 0; t < TAPS; t++) begin
            fir += tapWeight(t) * modelHist[t];
        end
        modelShifts++;
        if (warm) begin
            expQ.push_back(toOffsetBinary(fir + modelRec));
            modelWarmSent++;
        end
    end
endtask

`endif

/* tb/hybridDecimatorTb.sv */
`timescale 1ns/1ps
`default_nettype none

module hybridDecimatorTb import hybridPkg::*; ();

    // Frames per test including warm-up
    localparam int FRAMES_RESET = AHEAD_FRAMES + 1;
    localparam int FRAMES_FULL  = AHEAD_FRAMES + 200;
    localparam int FRAMES_GAPPY = AHEAD_FRAMES + 150;
    localparam int FRAMES_CONST = AHEAD_FRAMES + 40;
    localparam int FRAMES_HOLD  = AHEAD_FRAMES + QUEUE_DEPTH + 4;
    localparam int TOTAL_CODES  = DSR * (FRAMES_RESET + FRAMES_FULL + FRAMES_GAPPY
                                        + FRAMES_CONST + FRAMES_HOLD);
    localparam int CYCLE_LIMIT  = 4 * TOTAL_CODES + 2000;
    localparam int DRAIN_LIMIT  = 200;
    localparam int MIDSCALE     = 1 << (OUT_W - 1);

    logic               clkDS;
    logic               arstN;
    logic [M-1:0]       inCode;
    logic               inValid;
    logic [OUT_W-1:0]   outData;
    logic               outValid;
    logic               outReady;
    logic               overflow;

    integer             seed;
    int                 readyMode;
    int                 cycleCount;
    int                 failCount;
    int                 testStartFails;
    int                 testsPassed;
    int                 testsFailed;
    int                 codeIdx;
    int                 lastPopped;
    logic [FRAME_W-1:0] frameBits;
    string              curTest;

    `include "tbModel.svh"

    hybridDecimator hybridDecimator_i (
        .clkDS    (clkDS),
        .arstN    (arstN),
        .inCode   (inCode),
        .inValid  (inValid),
        .outData  (outData),
        .outValid (outValid),
        .outReady (outReady),
        .overflow (overflow)
    );

    initial begin
        clkDS = 1'b0;
        forever #10 clkDS = ~clkDS;
    end

    always @(posedge clkDS) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles in test %s", CYCLE_LIMIT, curTest);
            $display("sim failed");
            $finish;
        end
    end

    task automatic checkValue(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
            failCount++;
        end
    endtask

    task automatic reportError(input string msg);
        $display("[ERROR] %s", msg);
        failCount++;
    endtask

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Inputs change on the falling edge and the head entry is logged before the rising edge pops it
    task automatic tick();
        @(negedge clkDS);
        case (readyMode)
            0: outReady = 1'b1;
            1: outReady = (randBelow(4) != 0);
            default: outReady = 1'b0;
        endcase
        inValid = 1'b0;
        if (outValid && outReady) begin
            lastPopped = int'(outData);
            if (expQ.size() == 0) begin
                reportError($sformatf("%s: result %0d came out with none expected",
                                      curTest, outData));
            end else begin
                checkValue(curTest, expQ.pop_front(), int'(outData));
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) tick();
    endtask

    task automatic sendCode(input logic [M-1:0] code);
        tick();
        inCode = code;
        inValid = 1'b1;
        frameBits[M*codeIdx +: M] = code;
        codeIdx++;
        if (codeIdx == DSR) begin
            modelFrame(frameBits);
            codeIdx = 0;
        end
    endtask

    task automatic sendRandomFrames(input int n, input int maxGap);
        for (int i = 0; i < n * DSR; i++) begin
            sendCode(M'(randBelow(4)));
            if (maxGap > 0) begin
                idle(randBelow(maxGap + 1));
            end
        end
    endtask

    task automatic sendConstFrames(input int n, input logic [M-1:0] code);
        for (int i = 0; i < n * DSR; i++) begin
            sendCode(code);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (expQ.size() != 0 && waited < DRAIN_LIMIT) begin
            tick();
            waited++;
        end
        if (expQ.size() != 0) begin
            reportError($sformatf("%s: %0d expected results never came out",
                                  curTest, expQ.size()));
        end
        // Room for credits to travel back upstream
        idle(4);
        checkValue({curTest, " queue empty"}, 0, int'(outValid));
    endtask

    task automatic applyReset();
        @(negedge clkDS);
        arstN = 1'b0;
        inValid = 1'b0;
        inCode = '0;
        repeat (3) @(negedge clkDS);
        arstN = 1'b1;
        codeIdx = 0;
        modelReset();
    endtask

    task automatic startTest(input string name);
        curTest = name;
        testStartFails = failCount;
    endtask

    task automatic endTest();
        if (failCount == testStartFails) begin
            testsPassed++;
        end else begin
            testsFailed++;
        end
        $display("%s finished with %0d errors", curTest, failCount - testStartFails);
    endtask

    initial begin
        seed = 32'hae479287;
        arstN = 1'b0;
        inCode = '0;
        inValid = 1'b0;
        outReady = 1'b0;
        readyMode = 0;
        holdCredits = 1'b0;
        curTest = "init";

        startTest("resetQuiet");
        applyReset();
        checkValue({curTest, " outValid"}, 0, int'(outValid));
        checkValue({curTest, " overflow"}, 0, int'(overflow));
        sendRandomFrames(AHEAD_FRAMES, 0);
        repeat (10) begin
            tick();
            checkValue({curTest, " warm-up outValid"}, 0, int'(outValid));
        end
        sendRandomFrames(1, 0);
        drain();
        endTest();

        startTest("randomFullRate");
        applyReset();
        sendRandomFrames(FRAMES_FULL, 0);
        drain();
        checkValue({curTest, " overflow"}, 0, int'(overflow));
        endTest();

        startTest("randomGaps");
        readyMode = 1;
        applyReset();
        sendRandomFrames(FRAMES_GAPPY, 3);
        drain();
        checkValue({curTest, " overflow"}, 0, int'(overflow));
        endTest();

        startTest("constLevels");
        readyMode = 0;
        applyReset();
        sendConstFrames(AHEAD_FRAMES + 20, 2'd3);
        drain();
        checkValue({curTest, " high above midscale"}, 1, int'(lastPopped > MIDSCALE));
        sendConstFrames(20, 2'd0);
        drain();
        checkValue({curTest, " low below midscale"}, 1, int'(lastPopped < MIDSCALE));
        checkValue({curTest, " overflow"}, 0, int'(overflow));
        endTest();

        startTest("creditOverflow");
        readyMode = 2;
        applyReset();
        holdCredits = 1'b1;
        sendRandomFrames(AHEAD_FRAMES + QUEUE_DEPTH, 0);
        idle(6);
        checkValue({curTest, " overflow before drop"}, 0, int'(overflow));
        sendRandomFrames(1, 0);
        idle(3);
        checkValue({curTest, " overflow after drop"}, 1, int'(overflow));
        sendRandomFrames(3, 0);
        readyMode = 0;
        drain();
        checkValue({curTest, " overflow sticky"}, 1, int'(overflow));
        holdCredits = 1'b0;
        applyReset();
        checkValue({curTest, " overflow after reset"}, 0, int'(overflow));
        endTest();

        $display("%0d tests passed, %0d tests failed, %0d errors",
                 testsPassed, testsFailed, failCount);
        if (failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+tb
verilog/hybridPkg.sv
verilog/linkIfs.sv
verilog/sampleDeserializer.sv
verilog/lookaheadFir.sv
verilog/lookbackRecursion.sv
verilog/filterCore.sv
verilog/outputQueue.sv
verilog/hybridDecimator.sv
tb/hybridDecimatorTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the decimator testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module hybridDecimatorTb -f vlog.f
./obj_dir/VhybridDecimatorTb | tee sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log" >&2
exit 1
